// File: fadd_params.svh
`ifndef FADD_PARAMS_SVH
`define FADD_PARAMS_SVH

// Binary32 field layout
`define FADD_EXP_W  8
`define FADD_FRAC_W 23
`define FADD_WIDTH  32

`define FADD_BIAS   127

// Canonical quiet NaN
`define FADD_QNAN   32'h7FC0_0000

`endif

// File: fadd_pkg.sv
package fadd_pkg;

    // RISC-V frm encodings with codes 5 to 7 reserved
    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } rnd_mode_e;

    // Operand classes decoded in the unpack stage
    typedef enum logic [2:0] {
        ZERO      = 3'd0,
        SUBNORMAL = 3'd1,
        NORMAL    = 3'd2,
        INF       = 3'd3,
        QNAN      = 3'd4,
        SNAN      = 3'd5
    } fp_class_e;

    // Bit positions inside fflags
    localparam int FLAG_NX = 0;
    localparam int FLAG_UF = 1;
    localparam int FLAG_OF = 2;
    localparam int FLAG_DZ = 3;
    localparam int FLAG_NV = 4;

endpackage

// File: fadd_unpack.sv
`timescale 1ns/100ps
`include "fadd_params.svh"

module fadd_unpack import fadd_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   enable,
    input  logic                   in_valid,
    input  logic [2:0]             frm,
    input  logic [`FADD_WIDTH-1:0] a,
    input  logic [`FADD_WIDTH-1:0] b,
    output logic                   valid,
    output rnd_mode_e              rm,
    output logic                   a_sign,
    output logic                   b_sign,
    output fp_class_e              a_class,
    output fp_class_e              b_class,
    output logic [8:0]             a_exp,
    output logic [8:0]             b_exp,
    output logic [23:0]            a_sig,
    output logic [23:0]            b_sig
);

    localparam int EXP_LSB = `FADD_FRAC_W;
    localparam int EXP_MSB = `FADD_FRAC_W + `FADD_EXP_W - 1;

    function automatic fp_class_e classify(input logic [`FADD_EXP_W-1:0]  e,
                                           input logic [`FADD_FRAC_W-1:0] f);
        if (e == '0)
            return (f == '0) ? ZERO : SUBNORMAL;
        if (e == '1) begin
            if (f == '0)
                return INF;
            // Quiet bit is the fraction MSB
            return f[`FADD_FRAC_W-1] ? QNAN : SNAN;
        end
        return NORMAL;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (enable) begin
            valid <= in_valid;
        end
    end

    // Subnormals share exponent 1 with the smallest normals
    always_ff @(posedge clk) begin
        if (enable) begin
            rm      <= (frm > 3'd4) ? RNE : rnd_mode_e'(frm);
            a_sign  <= a[`FADD_WIDTH-1];
            b_sign  <= b[`FADD_WIDTH-1];
            a_class <= classify(a[EXP_MSB:EXP_LSB], a[`FADD_FRAC_W-1:0]);
            b_class <= classify(b[EXP_MSB:EXP_LSB], b[`FADD_FRAC_W-1:0]);
            a_exp   <= (a[EXP_MSB:EXP_LSB] == '0) ? 9'd1 : {1'b0, a[EXP_MSB:EXP_LSB]};
            b_exp   <= (b[EXP_MSB:EXP_LSB] == '0) ? 9'd1 : {1'b0, b[EXP_MSB:EXP_LSB]};
            a_sig   <= {a[EXP_MSB:EXP_LSB] != '0, a[`FADD_FRAC_W-1:0]};
            b_sig   <= {b[EXP_MSB:EXP_LSB] != '0, b[`FADD_FRAC_W-1:0]};
        end
    end

endmodule

// File: fadd_align.sv
`timescale 1ns/100ps
`include "fadd_params.svh"

module fadd_align import fadd_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   enable,
    input  logic                   s1_valid,
    input  rnd_mode_e              s1_rm,
    input  logic                   a_sign,
    input  logic                   b_sign,
    input  fp_class_e              a_class,
    input  fp_class_e              b_class,
    input  logic [8:0]             a_exp,
    input  logic [8:0]             b_exp,
    input  logic [23:0]            a_sig,
    input  logic [23:0]            b_sig,
    output logic                   valid,
    output rnd_mode_e              rm,
    output logic                   sign,
    output logic [8:0]             exp,
    output logic [26:0]            big_sig,
    output logic [26:0]            small_sig,
    output logic                   eff_sub,
    output logic                   special,
    output logic [`FADD_WIDTH-1:0] special_val,
    output logic                   invalid
);

    logic                   a_big;
    logic [8:0]             big_exp;
    logic [8:0]             small_exp;
    logic [26:0]            big_ext;
    logic [26:0]            small_ext;
    logic [8:0]             exp_diff;
    logic [4:0]             shamt;
    logic [26:0]            lost_mask;
    logic [26:0]            shifted;
    logic                   sticky;
    logic                   a_nan;
    logic                   b_nan;
    logic                   inf_clash;
    logic                   spec_n;
    logic                   inv_n;
    logic [`FADD_WIDTH-1:0] val_n;

    // Larger magnitude leads and ties keep a
    assign a_big     = {a_exp, a_sig} >= {b_exp, b_sig};
    assign big_exp   = a_big ? a_exp : b_exp;
    assign small_exp = a_big ? b_exp : a_exp;
    assign big_ext   = {a_big ? a_sig : b_sig, 3'b000};
    assign small_ext = {a_big ? b_sig : a_sig, 3'b000};

    // Past 27 positions nothing is left but sticky
    assign exp_diff  = big_exp - small_exp;
    assign shamt     = (exp_diff > 9'd27) ? 5'd27 : exp_diff[4:0];
    assign lost_mask = (27'd1 << shamt) - 27'd1;
    assign shifted   = small_ext >> shamt;
    assign sticky    = |(small_ext & lost_mask);

    assign a_nan     = (a_class == QNAN) || (a_class == SNAN);
    assign b_nan     = (b_class == QNAN) || (b_class == SNAN);
    assign inf_clash = (a_class == INF) && (b_class == INF) && (a_sign != b_sign);

    always_comb begin
        spec_n = 1'b1;
        inv_n  = 1'b0;
        val_n  = `FADD_QNAN;
        if (a_nan || b_nan) begin
            inv_n = (a_class == SNAN) || (b_class == SNAN);
        end else if (inf_clash) begin
            inv_n = 1'b1;
        end else if (a_class == INF) begin
            val_n = {a_sign, {`FADD_EXP_W{1'b1}}, {`FADD_FRAC_W{1'b0}}};
        end else if (b_class == INF) begin
            val_n = {b_sign, {`FADD_EXP_W{1'b1}}, {`FADD_FRAC_W{1'b0}}};
        end else begin
            spec_n = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (enable) begin
            valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            rm          <= s1_rm;
            sign        <= a_big ? a_sign : b_sign;
            exp         <= big_exp;
            big_sig     <= big_ext;
            small_sig   <= {shifted[26:1], shifted[0] | sticky};
            eff_sub     <= a_sign ^ b_sign;
            special     <= spec_n;
            special_val <= val_n;
            invalid     <= inv_n;
        end
    end

endmodule

// File: fadd_sum.sv
`timescale 1ns/100ps
`include "fadd_params.svh"

module fadd_sum import fadd_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   enable,
    input  logic                   s2_valid,
    input  rnd_mode_e              s2_rm,
    input  logic                   s2_sign,
    input  logic [8:0]             s2_exp,
    input  logic [26:0]            big_sig,
    input  logic [26:0]            small_sig,
    input  logic                   eff_sub,
    input  logic                   s2_special,
    input  logic [`FADD_WIDTH-1:0] s2_special_val,
    input  logic                   s2_invalid,
    output logic                   valid,
    output rnd_mode_e              rm,
    output logic                   sign,
    output logic signed [9:0]      exp,
    output logic [26:0]            sig,
    output logic                   exact_zero,
    output logic                   special,
    output logic [`FADD_WIDTH-1:0] special_val,
    output logic                   invalid
);

    logic [27:0] raw;
    logic [4:0]  lz;
    logic [8:0]  lim;
    logic [4:0]  lshamt;
    logic [26:0] norm_sig;
    logic [9:0]  norm_exp;

    // Leading zeros of a 27 bit value or 27 when all clear
    function automatic logic [4:0] lzc27(input logic [26:0] v);
        logic [4:0] n;
        logic       found;
        n     = 5'd27;
        found = 1'b0;
        for (int i = 26; i >= 0; i--) begin
            if (!found && v[i]) begin
                n     = 5'(26 - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    // big_sig is never below small_sig, so the difference stays positive
    assign raw = eff_sub ? ({1'b0, big_sig} - {1'b0, small_sig})
                         : ({1'b0, big_sig} + {1'b0, small_sig});

    // Left shift stops at exponent 1 and leaves subnormals denormalized
    assign lz     = lzc27(raw[26:0]);
    assign lim    = s2_exp - 9'd1;
    assign lshamt = ({4'b0, lz} < lim) ? lz : lim[4:0];

    always_comb begin
        if (raw[27]) begin
            norm_sig = {raw[27:2], raw[1] | raw[0]};
            norm_exp = {1'b0, s2_exp} + 10'd1;
        end else begin
            norm_sig = raw[26:0] << lshamt;
            norm_exp = {1'b0, s2_exp} - {5'b0, lshamt};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (enable) begin
            valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            rm          <= s2_rm;
            sign        <= s2_sign;
            exp         <= norm_exp;
            sig         <= norm_sig;
            exact_zero  <= eff_sub && (raw == '0);
            special     <= s2_special;
            special_val <= s2_special_val;
            invalid     <= s2_invalid;
        end
    end

endmodule

// File: fadd_round.sv
`timescale 1ns/100ps
`include "fadd_params.svh"

module fadd_round import fadd_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   enable,
    input  logic                   valid,
    input  rnd_mode_e              rm,
    input  logic                   sign,
    input  logic signed [9:0]      exp,
    input  logic [26:0]            sig,
    input  logic                   exact_zero,
    input  logic                   special,
    input  logic [`FADD_WIDTH-1:0] special_val,
    input  logic                   invalid,
    output logic                   out_valid,
    output logic [`FADD_WIDTH-1:0] y,
    output logic [4:0]             fflags
);

    localparam int EXP_MAX = 2 * `FADD_BIAS + 1;

    logic                   lsb;
    logic                   guard;
    logic                   rest;
    logic                   inexact;
    logic                   round_up;
    logic [24:0]            rounded;
    logic [23:0]            mant;
    logic signed [9:0]      exp_r;
    logic                   overflow;
    logic                   to_max;
    logic                   tiny;
    logic [`FADD_EXP_W-1:0] exp_field;
    logic [`FADD_WIDTH-1:0] y_n;
    logic [4:0]             flags_n;

    assign lsb     = sig[3];
    assign guard   = sig[2];
    assign rest    = sig[1] | sig[0];
    assign inexact = guard | rest;

    always_comb begin
        case (rm)
            RTZ:     round_up = 1'b0;
            RDN:     round_up = sign & inexact;
            RUP:     round_up = !sign & inexact;
            RMM:     round_up = guard;
            default: round_up = guard & (rest | lsb);
        endcase
    end

    assign rounded = {1'b0, sig[26:3]} + {24'b0, round_up};

    // Carry out of the significand bumps the exponent
    always_comb begin
        if (rounded[24]) begin
            mant  = rounded[24:1];
            exp_r = exp + 10'sd1;
        end else begin
            mant  = rounded[23:0];
            exp_r = exp;
        end
    end

    assign overflow = exp_r >= EXP_MAX;
    assign to_max   = (rm == RTZ) || ((rm == RDN) && !sign) || ((rm == RUP) && sign);

    // Without the hidden bit the result packs as subnormal
    assign tiny      = !mant[23];
    assign exp_field = mant[23] ? exp_r[`FADD_EXP_W-1:0] : '0;

    always_comb begin
        flags_n = '0;
        if (special) begin
            y_n              = special_val;
            flags_n[FLAG_NV] = invalid;
        end else if (exact_zero) begin
            // Cancellation gives +0 except when rounding down
            y_n = {rm == RDN, {(`FADD_WIDTH-1){1'b0}}};
        end else if (overflow) begin
            if (to_max)
                y_n = {sign, {(`FADD_EXP_W-1){1'b1}}, 1'b0, {`FADD_FRAC_W{1'b1}}};
            else
                y_n = {sign, {`FADD_EXP_W{1'b1}}, {`FADD_FRAC_W{1'b0}}};
            flags_n[FLAG_OF] = 1'b1;
            flags_n[FLAG_NX] = 1'b1;
        end else begin
            y_n              = {sign, exp_field, mant[`FADD_FRAC_W-1:0]};
            flags_n[FLAG_UF] = tiny & inexact;
            flags_n[FLAG_NX] = inexact;
        end
        // Addition never divides by zero
        flags_n[FLAG_DZ] = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (enable) begin
            out_valid <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            y      <= y_n;
            fflags <= flags_n;
        end
    end

endmodule

// File: fadd_top.sv
`timescale 1ns/100ps
`include "fadd_params.svh"

module fadd_top import fadd_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   enable,
    input  logic                   in_valid,
    input  logic [2:0]             frm,
    input  logic [`FADD_WIDTH-1:0] a,
    input  logic [`FADD_WIDTH-1:0] b,
    output logic                   out_valid,
    output logic [`FADD_WIDTH-1:0] y,
    output logic [4:0]             fflags
);

    // Unpack to align
    logic                   s1_valid;
    rnd_mode_e              s1_rm;
    logic                   s1_a_sign;
    logic                   s1_b_sign;
    fp_class_e              s1_a_class;
    fp_class_e              s1_b_class;
    logic [8:0]             s1_a_exp;
    logic [8:0]             s1_b_exp;
    logic [23:0]            s1_a_sig;
    logic [23:0]            s1_b_sig;

    // Align to sum
    logic                   s2_valid;
    rnd_mode_e              s2_rm;
    logic                   s2_sign;
    logic [8:0]             s2_exp;
    logic [26:0]            s2_big_sig;
    logic [26:0]            s2_small_sig;
    logic                   s2_eff_sub;
    logic                   s2_special;
    logic [`FADD_WIDTH-1:0] s2_special_val;
    logic                   s2_invalid;

    // Sum to round
    logic                   s3_valid;
    rnd_mode_e              s3_rm;
    logic                   s3_sign;
    logic signed [9:0]      s3_exp;
    logic [26:0]            s3_sig;
    logic                   s3_exact_zero;
    logic                   s3_special;
    logic [`FADD_WIDTH-1:0] s3_special_val;
    logic                   s3_invalid;

    fadd_unpack i_unpack (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .in_valid (in_valid),
        .frm      (frm),
        .a        (a),
        .b        (b),
        .valid    (s1_valid),
        .rm       (s1_rm),
        .a_sign   (s1_a_sign),
        .b_sign   (s1_b_sign),
        .a_class  (s1_a_class),
        .b_class  (s1_b_class),
        .a_exp    (s1_a_exp),
        .b_exp    (s1_b_exp),
        .a_sig    (s1_a_sig),
        .b_sig    (s1_b_sig)
    );

    fadd_align i_align (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .s1_valid    (s1_valid),
        .s1_rm       (s1_rm),
        .a_sign      (s1_a_sign),
        .b_sign      (s1_b_sign),
        .a_class     (s1_a_class),
        .b_class     (s1_b_class),
        .a_exp       (s1_a_exp),
        .b_exp       (s1_b_exp),
        .a_sig       (s1_a_sig),
        .b_sig       (s1_b_sig),
        .valid       (s2_valid),
        .rm          (s2_rm),
        .sign        (s2_sign),
        .exp         (s2_exp),
        .big_sig     (s2_big_sig),
        .small_sig   (s2_small_sig),
        .eff_sub     (s2_eff_sub),
        .special     (s2_special),
        .special_val (s2_special_val),
        .invalid     (s2_invalid)
    );

    fadd_sum i_sum (
        .clk            (clk),
        .rst_n          (rst_n),
        .enable         (enable),
        .s2_valid       (s2_valid),
        .s2_rm          (s2_rm),
        .s2_sign        (s2_sign),
        .s2_exp         (s2_exp),
        .big_sig        (s2_big_sig),
        .small_sig      (s2_small_sig),
        .eff_sub        (s2_eff_sub),
        .s2_special     (s2_special),
        .s2_special_val (s2_special_val),
        .s2_invalid     (s2_invalid),
        .valid          (s3_valid),
        .rm             (s3_rm),
        .sign           (s3_sign),
        .exp            (s3_exp),
        .sig            (s3_sig),
        .exact_zero     (s3_exact_zero),
        .special        (s3_special),
        .special_val    (s3_special_val),
        .invalid        (s3_invalid)
    );

    fadd_round i_round (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .valid       (s3_valid),
        .rm          (s3_rm),
        .sign        (s3_sign),
        .exp         (s3_exp),
        .sig         (s3_sig),
        .exact_zero  (s3_exact_zero),
        .special     (s3_special),
        .special_val (s3_special_val),
        .invalid     (s3_invalid),
        .out_valid   (out_valid),
        .y           (y),
        .fflags      (fflags)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 40.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

// File: tb_fadd.sv
`timescale 1ns/100ps
`include "fadd_params.svh"

module tb_fadd import fadd_pkg::*; ();

    // Directed plus streaming operations, and a budget for stalled cycles
    localparam int OP_COUNT        = 74;
    localparam int STALL_CYCLES    = 126;
    localparam int WATCHDOG_CYCLES = 10 * (OP_COUNT + STALL_CYCLES);
    localparam int STREAM_OPS      = 40;
    localparam int STREAM_LIMIT    = 400;
    localparam int RESULT_WAIT     = 12;

    logic                   clk;
    logic                   rst_n;
    logic                   enable;
    logic                   in_valid;
    logic [2:0]             frm;
    logic [`FADD_WIDTH-1:0] a;
    logic [`FADD_WIDTH-1:0] b;
    logic                   out_valid;
    logic [`FADD_WIDTH-1:0] y;
    logic [4:0]             fflags;

    logic [31:0]            rng_state;
    logic [31:0]            res_y[$];
    logic [4:0]             res_flags[$];
    bit                     stream_done;

    tb_clock_gen i_clock_gen (
        .clk (clk)
    );

    fadd_top i_fadd_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .in_valid  (in_valid),
        .frm       (frm),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .y         (y),
        .fflags    (fflags)
    );

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Any exponent field except all ones
    function automatic logic [31:0] rand_finite();
        logic [31:0] r;
        r = next_rand();
        if (r[30:23] == 8'hFF)
            r[30] = 1'b0;
        return r;
    endfunction

    // Exponent within a few binades of x so the significands overlap
    function automatic logic [31:0] rand_near(input logic [31:0] x);
        logic [31:0] r;
        r = next_rand();
        r[30:23] = x[30:23] ^ {5'b0, r[2:0]};
        if (r[30:23] == 8'hFF)
            r[30] = 1'b0;
        return r;
    endfunction

    function automatic logic [4:0] make_flags(input bit nv, input bit of,
                                              input bit uf, input bit nx);
        logic [4:0] f;
        f          = '0;
        f[FLAG_NV] = nv;
        f[FLAG_OF] = of;
        f[FLAG_UF] = uf;
        f[FLAG_NX] = nx;
        return f;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_equal(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            abort_run($sformatf("Fail at %0d ns: %s, got 0x%08h, expected 0x%08h",
                                $time, what, actual, expected));
    endtask

    // One operation through an idle pipeline
    task automatic run_op(input string name, input logic [2:0] mode,
                          input logic [31:0] op_a, input logic [31:0] op_b,
                          input logic [31:0] exp_y, input logic [4:0] exp_flags);
        int waited;
        waited = 0;
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        frm      = mode;
        a        = op_a;
        b        = op_b;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!out_valid && waited < RESULT_WAIT);
        if (!out_valid) begin
            abort_run($sformatf("%s: DUT gave no out_valid within %0d cycles",
                                name, RESULT_WAIT));
        end else begin
            check_equal({name, " result"}, y, exp_y);
            check_equal({name, " flags"}, fflags, exp_flags);
        end
    endtask

    task automatic test_exact();
        run_op("1.0+2.0", RNE, 32'h3F80_0000, 32'h4000_0000, 32'h4040_0000, 5'b0);
        run_op("1.5-0.5", RNE, 32'h3FC0_0000, 32'hBF00_0000, 32'h3F80_0000, 5'b0);
        run_op("1.0+0", RNE, 32'h3F80_0000, 32'h0000_0000, 32'h3F80_0000, 5'b0);
        run_op("-123.456+0", RNE, 32'hC2F6_E979, 32'h0000_0000, 32'hC2F6_E979, 5'b0);
        run_op("subnormal+0", RNE, 32'h0000_0005, 32'h0000_0000, 32'h0000_0005, 5'b0);
        run_op("max+0", RNE, 32'h7F7F_FFFF, 32'h0000_0000, 32'h7F7F_FFFF, 5'b0);
        run_op("0+pi", RNE, 32'h0000_0000, 32'h4049_0FDB, 32'h4049_0FDB, 5'b0);
    endtask

    task automatic test_specials();
        logic [4:0] nv;
        nv = make_flags(1, 0, 0, 0);
        run_op("+inf-inf", RNE, 32'h7F80_0000, 32'hFF80_0000, `FADD_QNAN, nv);
        run_op("sNaN+1", RNE, 32'h7F80_0001, 32'h3F80_0000, `FADD_QNAN, nv);
        run_op("1+sNaN", RNE, 32'h3F80_0000, 32'hFFA0_0000, `FADD_QNAN, nv);
        run_op("qNaN+1", RNE, 32'hFFC1_2345, 32'h3F80_0000, `FADD_QNAN, 5'b0);
        run_op("-inf+42", RNE, 32'hFF80_0000, 32'h4228_0000, 32'hFF80_0000, 5'b0);
        run_op("1+inf", RNE, 32'h3F80_0000, 32'h7F80_0000, 32'h7F80_0000, 5'b0);
    endtask

    // 1.0 + 2^-24 lies exactly halfway between 1.0 and its successor
    task automatic test_rounding();
        logic [2:0]  modes[6];
        bit          away;
        logic [31:0] sgn;
        string       name;
        modes = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd7};
        for (int neg = 0; neg < 2; neg++) begin
            for (int i = 0; i < 6; i++) begin
                // Reserved code 7 rounds like RNE, which keeps the even 1.0
                away = (modes[i] == RMM) || (modes[i] == RUP && neg == 0) ||
                       (modes[i] == RDN && neg == 1);
                sgn  = (neg != 0) ? 32'h8000_0000 : 32'h0;
                name = $sformatf("tie mode %0d sign %0d", modes[i], neg);
                run_op(name, modes[i], sgn | 32'h3F80_0000, sgn | 32'h3380_0000,
                       sgn | (32'h3F80_0000 + {31'b0, away}), make_flags(0, 0, 0, 1));
            end
        end
    endtask

    task automatic test_overflow();
        logic [4:0] ovf;
        ovf = make_flags(0, 1, 0, 1);
        run_op("max+max RNE", RNE, 32'h7F7F_FFFF, 32'h7F7F_FFFF, 32'h7F80_0000, ovf);
        run_op("max+max RTZ", RTZ, 32'h7F7F_FFFF, 32'h7F7F_FFFF, 32'h7F7F_FFFF, ovf);
        run_op("-max-max RUP", RUP, 32'hFF7F_FFFF, 32'hFF7F_FFFF, 32'hFF7F_FFFF, ovf);
        run_op("-max-max RDN", RDN, 32'hFF7F_FFFF, 32'hFF7F_FFFF, 32'hFF80_0000, ovf);
    endtask

    task automatic test_cancel();
        run_op("x-x RNE", RNE, 32'h4049_0FDB, 32'hC049_0FDB, 32'h0000_0000, 5'b0);
        run_op("x-x RDN", RDN, 32'h4049_0FDB, 32'hC049_0FDB, 32'h8000_0000, 5'b0);
        run_op("-0+-0", RNE, 32'h8000_0000, 32'h8000_0000, 32'h8000_0000, 5'b0);
        run_op("min sub+min sub", RNE, 32'h0000_0001, 32'h0000_0001, 32'h0000_0002, 5'b0);
        run_op("min norm-min sub", RNE, 32'h0080_0000, 32'h8000_0001, 32'h007F_FFFF, 5'b0);
    endtask

    // Holds the operation on the inputs until an enabled edge takes it
    task automatic send_held(input logic [2:0] mode, input logic [31:0] op_a,
                             input logic [31:0] op_b);
        bit taken;
        taken    = 1'b0;
        in_valid = 1'b1;
        frm      = mode;
        a        = op_a;
        b        = op_b;
        while (!taken) begin
            enable = (next_rand() % 4) != 0;
            @(posedge clk);
            #2;
            taken = enable;
        end
    endtask

    task automatic drive_stream();
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [2:0]  mode;
        @(posedge clk);
        #2;
        for (int k = 0; k < STREAM_OPS / 2; k++) begin
            op_a = rand_finite();
            op_b = k[0] ? rand_finite() : rand_near(op_a);
            mode = 3'(next_rand() % 5);
            send_held(mode, op_a, op_b);
            send_held(mode, op_b, op_a);
        end
        in_valid = 1'b0;
        repeat (6) begin
            enable = (next_rand() % 4) != 0;
            @(posedge clk);
            #2;
        end
        enable      = 1'b1;
        stream_done = 1'b1;
    endtask

    task automatic collect_results();
        int          cycles;
        logic        prev_valid;
        logic [31:0] prev_y;
        logic [4:0]  prev_flags;
        cycles     = 0;
        prev_valid = out_valid;
        prev_y     = y;
        prev_flags = fflags;
        while (!(stream_done && res_y.size() >= STREAM_OPS) && cycles < STREAM_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
            if (!enable) begin
                // Outputs must hold on a stalled edge
                check_equal("out_valid during stall", out_valid, prev_valid);
                check_equal("y during stall", y, prev_y);
                check_equal("fflags during stall", fflags, prev_flags);
            end else if (out_valid) begin
                res_y.push_back(y);
                res_flags.push_back(fflags);
            end
            prev_valid = out_valid;
            prev_y     = y;
            prev_flags = fflags;
        end
        if (res_y.size() < STREAM_OPS)
            abort_run($sformatf("Streaming test timed out with %0d of %0d results",
                                res_y.size(), STREAM_OPS));
    endtask

    task automatic test_stream();
        int extra;
        extra       = 0;
        stream_done = 1'b0;
        res_y.delete();
        res_flags.delete();
        fork
            drive_stream();
            collect_results();
        join
        // No further pulses once the pipeline has drained
        repeat (8) begin
            @(posedge clk);
            #1;
            if (out_valid)
                extra++;
        end
        check_equal("out_valid pulse count", res_y.size() + extra, STREAM_OPS);
        for (int k = 0; k < STREAM_OPS; k += 2) begin
            check_equal($sformatf("stream pair %0d result", k / 2), res_y[k + 1], res_y[k]);
            check_equal($sformatf("stream pair %0d flags", k / 2),
                        res_flags[k + 1], res_flags[k]);
        end
    endtask

    initial begin
        rng_state = 32'd72;
        rst_n     = 1'b0;
        enable    = 1'b1;
        in_valid  = 1'b0;
        frm       = 3'd0;
        a         = '0;
        b         = '0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_equal("out_valid after reset", out_valid, 1'b0);
        test_exact();
        test_specials();
        test_rounding();
        test_overflow();
        test_cancel();
        test_stream();
        $display("PASS: all tests");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("Watchdog expired after %0d clock cycles, the DUT appears hung",
                            WATCHDOG_CYCLES));
    end

endmodule

// File: list.f
+incdir+.
fadd_pkg.sv
fadd_unpack.sv
fadd_align.sv
fadd_sum.sv
fadd_round.sv
fadd_top.sv
tb_clock_gen.sv
tb_fadd.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_fadd
FILELIST  = list.f
PASS_MSG  = PASS: all tests
SIM       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

# Build the simulation executable from the file list
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Run and decide pass or fail from the printed output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
